/* common/ooo_core_consts.svh */
`ifndef OOO_CORE_CONSTS_SVH
`define OOO_CORE_CONSTS_SVH

// architectural registers including x0
`define OOO_ARCH_REGS 32

// tag 0 is the hardwired zero
`define OOO_PHYS_REGS 64

// tags not mapped after reset
`define OOO_FREE_REGS (`OOO_PHYS_REGS - `OOO_ARCH_REGS)

// in-flight limits
`define OOO_ROB_DEPTH 16
`define OOO_RS_DEPTH 8

`endif

/* common/ooo_core_pkg.sv */
`default_nettype none

`include "ooo_core_consts.svh"

package ooo_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`OOO_PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    // decoded instruction at the core input
    typedef struct packed {
        alu_op_e   op;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      use_imm;
        word_t     imm;
    } inst_t;

    typedef struct packed {
        alu_op_e   op;
        logic      use_imm;
        word_t     imm;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        logic      src1_ready;
        logic      src2_ready;
        phys_tag_t dest_tag;
        rob_idx_t  rob_idx;
    } dispatch_t;

    // one result broadcast per cycle
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        rob_idx_t  rob_idx;
        word_t     value;
    } wb_t;

    typedef struct packed {
        arch_reg_t rd;
        word_t     value;
    } commit_t;

endpackage

`default_nettype wire

/* issue/alu_station.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module alu_station (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          dispatch_valid,
    input  wire ooo_core_pkg::dispatch_t dispatch,
    output logic                         has_space,
    output ooo_core_pkg::phys_tag_t      op_tag1,
    output ooo_core_pkg::phys_tag_t      op_tag2,
    input  wire ooo_core_pkg::word_t     op_val1,
    input  wire ooo_core_pkg::word_t     op_val2,
    output ooo_core_pkg::wb_t            wb
);

    localparam int DEPTH = `OOO_RS_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    ooo_core_pkg::dispatch_t slots [DEPTH];
    logic [DEPTH-1:0] slot_valid;
    logic [DEPTH-1:0] slot_ready;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] issue_idx;
    logic issue_valid;
    ooo_core_pkg::dispatch_t issue_ent;
    ooo_core_pkg::word_t alu_b;
    ooo_core_pkg::word_t alu_y;

    assign has_space = !(&slot_valid);

    // lowest free slot and lowest ready slot
    always_comb begin
        free_idx = '0;
        issue_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            slot_ready[i] = slot_valid[i] && slots[i].src1_ready && slots[i].src2_ready;
            if (!slot_valid[i])
                free_idx = IDX_W'(i);
            if (slot_ready[i])
                issue_idx = IDX_W'(i);
        end
        issue_valid = |slot_ready;
    end

    assign issue_ent = slots[issue_idx];
    assign op_tag1 = issue_ent.src1_tag;
    assign op_tag2 = issue_ent.src2_tag;
    assign alu_b = issue_ent.use_imm ? issue_ent.imm : op_val2;

    always_comb begin
        case (issue_ent.op)
            ooo_core_pkg::ALU_ADD: alu_y = op_val1 + alu_b;
            ooo_core_pkg::ALU_SUB: alu_y = op_val1 - alu_b;
            ooo_core_pkg::ALU_AND: alu_y = op_val1 & alu_b;
            ooo_core_pkg::ALU_OR:  alu_y = op_val1 | alu_b;
            ooo_core_pkg::ALU_XOR: alu_y = op_val1 ^ alu_b;
            ooo_core_pkg::ALU_SLL: alu_y = op_val1 << alu_b[4:0];
            ooo_core_pkg::ALU_SRL: alu_y = op_val1 >> alu_b[4:0];
            ooo_core_pkg::ALU_SLT: alu_y = {31'b0, $signed(op_val1) < $signed(alu_b)};
            default:               alu_y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
        end else begin
            if (issue_valid)
                slot_valid[issue_idx] <= 1'b0;
            if (dispatch_valid)
                slot_valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin    // wakeup
            if (wb.valid && slots[i].src1_tag == wb.tag)
                slots[i].src1_ready <= 1'b1;
            if (wb.valid && slots[i].src2_tag == wb.tag)
                slots[i].src2_ready <= 1'b1;
        end
        if (dispatch_valid) begin
            slots[free_idx] <= dispatch;
            // catch a broadcast in the dispatch cycle
            slots[free_idx].src1_ready <= dispatch.src1_ready ||
                (wb.valid && wb.tag == dispatch.src1_tag);
            slots[free_idx].src2_ready <= dispatch.src2_ready ||
                (wb.valid && wb.tag == dispatch.src2_tag);
        end
    end

    always_ff @(posedge clk) begin
        wb.tag <= issue_ent.dest_tag;
        wb.rob_idx <= issue_ent.rob_idx;
        wb.value <= alu_y;
        if (rst)
            wb.valid <= 1'b0;
        else
            wb.valid <= issue_valid;
    end

    a_dispatch_has_slot: assert property (
        @(posedge clk) disable iff (rst) dispatch_valid |-> has_space
    );

endmodule

`default_nettype wire

/* ooo_core.f */
+incdir+common
+incdir+testbench
common/ooo_core_pkg.sv
source/phys_regfile.sv
rename/rename_map.sv
issue/alu_station.sv
rob/reorder_buffer.sv
source/ooo_core.sv
testbench/ooo_core_tb.sv

/* rename/rename_map.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module rename_map (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            accept,
    input  wire ooo_core_pkg::inst_t       inst,
    input  wire                            src1_ready,
    input  wire                            src2_ready,
    input  wire ooo_core_pkg::rob_idx_t    rob_tail,
    input  wire                            release_valid,
    input  wire ooo_core_pkg::phys_tag_t   release_tag,
    output ooo_core_pkg::phys_tag_t        src1_tag,
    output ooo_core_pkg::phys_tag_t        src2_tag,
    output logic                           can_alloc,
    output ooo_core_pkg::dispatch_t        dispatch,
    output ooo_core_pkg::phys_tag_t        old_tag,
    output ooo_core_pkg::phys_tag_t        dest_tag
);

    localparam int FL_DEPTH = `OOO_FREE_REGS;
    localparam int FL_W = $clog2(FL_DEPTH);
    localparam int CNT_W = FL_W + 1;

    ooo_core_pkg::phys_tag_t rat [`OOO_ARCH_REGS];
    ooo_core_pkg::phys_tag_t free_tags [FL_DEPTH];
    logic [FL_W-1:0] fl_head;
    logic [FL_W-1:0] fl_tail;
    logic [CNT_W-1:0] fl_count;
    logic pop;
    logic push;

    assign can_alloc = fl_count != '0;
    assign pop = accept && inst.rd != '0;        // x0 never takes a tag
    assign push = release_valid && release_tag != '0;

    assign src1_tag = rat[inst.rs1];
    assign src2_tag = rat[inst.rs2];
    assign old_tag = rat[inst.rd];
    assign dest_tag = (inst.rd != '0) ? free_tags[fl_head] : '0;

    always_comb begin
        dispatch.op = inst.op;
        dispatch.use_imm = inst.use_imm;
        dispatch.imm = inst.imm;
        dispatch.src1_tag = src1_tag;
        dispatch.src2_tag = src2_tag;
        dispatch.src1_ready = src1_ready;
        dispatch.src2_ready = src2_ready || inst.use_imm;   // imm needs no wait
        dispatch.dest_tag = dest_tag;
        dispatch.rob_idx = rob_tail;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity map with the upper tags free
            for (int i = 0; i < `OOO_ARCH_REGS; i++)
                rat[i] <= ooo_core_pkg::phys_tag_t'(i);
            for (int i = 0; i < FL_DEPTH; i++)
                free_tags[i] <= ooo_core_pkg::phys_tag_t'(`OOO_ARCH_REGS + i);
            fl_head <= '0;
            fl_tail <= '0;
            fl_count <= CNT_W'(FL_DEPTH);
        end else begin
            if (pop) begin
                rat[inst.rd] <= dest_tag;
                fl_head <= fl_head + 1'b1;
            end
            if (push) begin
                free_tags[fl_tail] <= release_tag;
                fl_tail <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_accept_needs_tag: assert property (
        @(posedge clk) disable iff (rst) accept |-> can_alloc
    );

endmodule

`default_nettype wire

/* rob/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module reorder_buffer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          alloc_valid,
    input  wire ooo_core_pkg::arch_reg_t alloc_rd,
    input  wire ooo_core_pkg::phys_tag_t alloc_old_tag,
    output ooo_core_pkg::rob_idx_t       tail,
    output logic                         full,
    input  wire ooo_core_pkg::wb_t       wb,
    output logic                         commit_valid,
    output ooo_core_pkg::commit_t        commit_data,
    input  wire                          commit_ready,
    output logic                         release_valid,
    output ooo_core_pkg::phys_tag_t      release_tag
);

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    ooo_core_pkg::arch_reg_t ent_rd [DEPTH];
    ooo_core_pkg::phys_tag_t ent_old [DEPTH];
    ooo_core_pkg::word_t ent_value [DEPTH];
    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] done;
    ooo_core_pkg::rob_idx_t head;
    logic [CNT_W-1:0] count;
    logic fire;

    assign full = count == CNT_W'(DEPTH);

    // head retires only once its result is in
    assign commit_valid = busy[head] && done[head];
    assign commit_data = '{rd: ent_rd[head], value: ent_value[head]};
    assign fire = commit_valid && commit_ready;

    assign release_valid = fire && ent_rd[head] != '0;
    assign release_tag = ent_old[head];        // previous mapping goes back to the free list

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            busy <= '0;
            done <= '0;
        end else begin
            if (alloc_valid) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (wb.valid)
                done[wb.rob_idx] <= 1'b1;
            if (fire) begin
                busy[head] <= 1'b0;
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc_valid) - CNT_W'(fire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_rd[tail] <= alloc_rd;
            ent_old[tail] <= alloc_old_tag;
        end
        if (wb.valid)
            ent_value[wb.rob_idx] <= wb.value;
    end

    // each slot sees exactly one result per allocation
    a_wb_targets_pending: assert property (
        @(posedge clk) disable iff (rst)
        wb.valid |-> busy[wb.rob_idx] && !done[wb.rob_idx]
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f ooo_core.f ||
exit 1
./obj_dir/Vooo_core_tb > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1

/* source/ooo_core.sv */
`timescale 1ns/1ns
`default_nettype none

module ooo_core (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        in_valid,
    input  wire ooo_core_pkg::inst_t   in_inst,
    output logic                       in_ready,
    output logic                       commit_valid,
    output ooo_core_pkg::commit_t      commit_data,
    input  wire                        commit_ready
);

    ooo_core_pkg::phys_tag_t src1_tag;
    ooo_core_pkg::phys_tag_t src2_tag;
    ooo_core_pkg::phys_tag_t old_tag;
    ooo_core_pkg::phys_tag_t dest_tag;
    ooo_core_pkg::phys_tag_t release_tag;
    ooo_core_pkg::phys_tag_t op_tag1;
    ooo_core_pkg::phys_tag_t op_tag2;
    ooo_core_pkg::word_t op_val1;
    ooo_core_pkg::word_t op_val2;
    ooo_core_pkg::rob_idx_t rob_tail;
    ooo_core_pkg::dispatch_t dispatch;
    ooo_core_pkg::wb_t wb;
    logic src1_ready;
    logic src2_ready;
    logic can_alloc;
    logic rs_has_space;
    logic rob_full;
    logic release_valid;
    logic accept;

    // room in rob, station and free list
    assign in_ready = !rob_full && rs_has_space && can_alloc;
    assign accept = in_valid && in_ready;

    rename_map u_rename_map (
        .clk(clk),
        .rst(rst),
        .accept(accept),
        .inst(in_inst),
        .src1_ready(src1_ready),
        .src2_ready(src2_ready),
        .rob_tail(rob_tail),
        .release_valid(release_valid),
        .release_tag(release_tag),
        .src1_tag(src1_tag),
        .src2_tag(src2_tag),
        .can_alloc(can_alloc),
        .dispatch(dispatch),
        .old_tag(old_tag),
        .dest_tag(dest_tag)
    );

    phys_regfile u_phys_regfile (
        .clk(clk),
        .rst(rst),
        .rd_tag1(src1_tag),
        .rd_tag2(src2_tag),
        .ready1(src1_ready),
        .ready2(src2_ready),
        .alloc_valid(accept),      // tag 0 for x0 is ignored inside
        .alloc_tag(dest_tag),
        .wb(wb),
        .op_tag1(op_tag1),
        .op_tag2(op_tag2),
        .op_val1(op_val1),
        .op_val2(op_val2)
    );

    alu_station u_alu_station (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(accept),
        .dispatch(dispatch),
        .has_space(rs_has_space),
        .op_tag1(op_tag1),
        .op_tag2(op_tag2),
        .op_val1(op_val1),
        .op_val2(op_val2),
        .wb(wb)
    );

    reorder_buffer u_reorder_buffer (
        .clk(clk),
        .rst(rst),
        .alloc_valid(accept),
        .alloc_rd(in_inst.rd),
        .alloc_old_tag(old_tag),
        .tail(rob_tail),
        .full(rob_full),
        .wb(wb),
        .commit_valid(commit_valid),
        .commit_data(commit_data),
        .commit_ready(commit_ready),
        .release_valid(release_valid),
        .release_tag(release_tag)
    );

endmodule

`default_nettype wire

/* source/phys_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module phys_regfile (
    input  wire                          clk,
    input  wire                          rst,
    input  wire ooo_core_pkg::phys_tag_t rd_tag1,
    input  wire ooo_core_pkg::phys_tag_t rd_tag2,
    output logic                         ready1,
    output logic                         ready2,
    input  wire                          alloc_valid,
    input  wire ooo_core_pkg::phys_tag_t alloc_tag,
    input  wire ooo_core_pkg::wb_t       wb,
    input  wire ooo_core_pkg::phys_tag_t op_tag1,
    input  wire ooo_core_pkg::phys_tag_t op_tag2,
    output ooo_core_pkg::word_t          op_val1,
    output ooo_core_pkg::word_t          op_val2
);

    ooo_core_pkg::word_t regs [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] valid;

    // rename side lookups
    assign ready1 = valid[rd_tag1];
    assign ready2 = valid[rd_tag2];

    // issue side operand reads
    assign op_val1 = regs[op_tag1];
    assign op_val2 = regs[op_tag2];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '1;
            for (int i = 0; i < `OOO_PHYS_REGS; i++)
                regs[i] <= '0;
        end else begin
            if (wb.valid && wb.tag != '0) begin    // tag 0 stays zero
                regs[wb.tag] <= wb.value;
                valid[wb.tag] <= 1'b1;
            end
            if (alloc_valid && alloc_tag != '0)
                valid[alloc_tag] <= 1'b0;          // pending until its wb
        end
    end

endmodule

`default_nettype wire

/* testbench/ooo_core_checks.svh */
`ifndef OOO_CORE_CHECKS_SVH
`define OOO_CORE_CHECKS_SVH

`include "ooo_core_consts.svh"

// architectural state in program order
ooo_core_pkg::word_t shadow [`OOO_ARCH_REGS];
ooo_core_pkg::commit_t expect_q [$];   // expected commits in program order
int errors = 0;
int checks = 0;
string test_name = "reset";

function automatic ooo_core_pkg::word_t read_arch(input ooo_core_pkg::arch_reg_t r);
    if (r == 5'd0)
        return 32'd0;   // x0 always reads zero
    return shadow[r];
endfunction

function automatic ooo_core_pkg::commit_t ref_execute(input ooo_core_pkg::inst_t inst);
    ooo_core_pkg::word_t a;
    ooo_core_pkg::word_t b;
    ooo_core_pkg::word_t y;
    ooo_core_pkg::commit_t res;
    int sa;
    int sb;
    a = read_arch(inst.rs1);
    b = inst.use_imm ? inst.imm : read_arch(inst.rs2);
    sa = a;
    sb = b;
    case (inst.op)
        ooo_core_pkg::ALU_ADD: y = a + b;
        ooo_core_pkg::ALU_SUB: y = a - b;
        ooo_core_pkg::ALU_AND: y = a & b;
        ooo_core_pkg::ALU_OR:  y = a | b;
        ooo_core_pkg::ALU_XOR: y = a ^ b;
        ooo_core_pkg::ALU_SLL: y = a << (b % 32);   // shift amount from low 5 bits
        ooo_core_pkg::ALU_SRL: y = a >> (b % 32);
        default:               y = (sa < sb) ? 32'd1 : 32'd0;
    endcase
    if (inst.rd != 5'd0)
        shadow[inst.rd] = y;
    res.rd = inst.rd;
    res.value = y;   // x0 writes still carry the result to commit
    return res;
endfunction

task automatic check_commit(input ooo_core_pkg::commit_t exp, input ooo_core_pkg::commit_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("CHECK FAILED %s: expected x%0d = %08h, actual x%0d = %08h",
                 test_name, exp.rd, exp.value, act.rd, act.value);
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    checks++;
    if (act != exp) begin
        errors++;
        $display("CHECK FAILED %s: %s expected %0d, actual %0d", test_name, what, exp, act);
    end
endtask

`endif

/* testbench/ooo_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ooo_core_tb;

    localparam int CLK_PERIOD = 10;
    localparam int OP_INSTS = 8 * 2 * 4 * 3;
    localparam int CHAIN_INSTS = 4 * 20;
    localparam int STALL_INSTS = 150;
    localparam int RECYCLE_INSTS = 250;
    localparam int ZERO_INSTS = 2 * 10;
    localparam int TOTAL_INSTS = OP_INSTS + CHAIN_INSTS + STALL_INSTS + RECYCLE_INSTS
                                 + ZERO_INSTS;

    logic clk = 1'b0;
    logic rst;
    logic in_valid;
    ooo_core_pkg::inst_t in_inst;
    logic in_ready;
    logic commit_valid;
    ooo_core_pkg::commit_t commit_data;
    logic commit_ready = 1'b1;
    logic stall_mode = 1'b0;
    logic saw_full = 1'b0;
    int unsigned hold_cnt = 0;
    int sent = 0;
    int committed = 0;

    `include "ooo_core_checks.svh"

    ooo_core ooo_core_i (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_inst(in_inst),
        .in_ready(in_ready),
        .commit_valid(commit_valid),
        .commit_data(commit_data),
        .commit_ready(commit_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // commit monitor
    always @(posedge clk) begin
        if (!rst && commit_valid && commit_ready) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("%s: x%0d committed with no instruction outstanding",
                         test_name, commit_data.rd);
            end else begin
                check_commit(expect_q.pop_front(), commit_data);
            end
            committed++;
        end
    end

    // long stalls with short release windows
    always @(negedge clk) begin
        if (!stall_mode) begin
            commit_ready = 1'b1;
        end else if (hold_cnt == 0) begin
            commit_ready = !commit_ready;
            hold_cnt = commit_ready ? $urandom_range(6, 1) : $urandom_range(60, 20);
        end else begin
            hold_cnt--;
        end
        if (stall_mode && !in_ready)
            saw_full = 1'b1;
    end

    function automatic ooo_core_pkg::inst_t make_inst(input ooo_core_pkg::alu_op_e op,
            input ooo_core_pkg::arch_reg_t rd, input ooo_core_pkg::arch_reg_t rs1,
            input ooo_core_pkg::arch_reg_t rs2, input logic use_imm,
            input ooo_core_pkg::word_t imm);
        ooo_core_pkg::inst_t inst;
        inst.op = op;
        inst.rd = rd;
        inst.rs1 = rs1;
        inst.rs2 = rs2;
        inst.use_imm = use_imm;
        inst.imm = imm;
        return inst;
    endfunction

    function automatic ooo_core_pkg::inst_t rand_inst(input bit allow_x0);
        ooo_core_pkg::inst_t inst;
        inst.op = ooo_core_pkg::alu_op_e'($urandom_range(7, 0));
        inst.rd = ooo_core_pkg::arch_reg_t'($urandom_range(31, allow_x0 ? 0 : 1));
        inst.rs1 = ooo_core_pkg::arch_reg_t'($urandom_range(31, 0));
        inst.rs2 = ooo_core_pkg::arch_reg_t'($urandom_range(31, 0));
        inst.use_imm = $urandom_range(1, 0) == 1;
        inst.imm = $urandom();
        return inst;
    endfunction

    // held until in_ready then transferred on the next rising edge
    task automatic send_inst(input ooo_core_pkg::inst_t inst);
        @(negedge clk);
        in_valid = 1'b1;
        in_inst = inst;
        while (!in_ready)
            @(negedge clk);
        expect_q.push_back(ref_execute(inst));
        sent++;
        @(posedge clk);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        idle_cycle();
        while (expect_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);   // a stray extra commit would land here
    endtask

    task automatic op_sweep();
        ooo_core_pkg::alu_op_e op;
        ooo_core_pkg::word_t a;
        ooo_core_pkg::word_t b;
        test_name = "op_sweep";
        for (int i = 0; i < 8; i++) begin
            op = ooo_core_pkg::alu_op_e'(i);
            for (int form = 0; form < 2; form++) begin
                repeat (4) begin
                    a = $urandom();
                    b = $urandom();
                    send_inst(make_inst(ooo_core_pkg::ALU_ADD, 5'd1, 5'd0, 5'd0, 1'b1, a));
                    send_inst(make_inst(ooo_core_pkg::ALU_ADD, 5'd2, 5'd0, 5'd0, 1'b1, b));
                    send_inst(make_inst(op, 5'd3, 5'd1, 5'd2, form == 1, b));
                end
            end
        end
        wait_drain();
    endtask

    task automatic dependency_chains();
        ooo_core_pkg::inst_t inst;
        ooo_core_pkg::arch_reg_t prev;
        test_name = "dependency_chains";
        repeat (4) begin
            prev = ooo_core_pkg::arch_reg_t'($urandom_range(31, 1));
            send_inst(make_inst(ooo_core_pkg::ALU_ADD, prev, 5'd0, 5'd0, 1'b1, $urandom()));
            repeat (19) begin
                inst = rand_inst(1'b0);
                inst.rs1 = prev;             // each source is the last result
                if ($urandom_range(1, 0) == 1)
                    inst.rs2 = prev;
                send_inst(inst);
                prev = inst.rd;
            end
        end
        wait_drain();
    endtask

    task automatic backpressure_burst();
        int sent0;
        int committed0;
        test_name = "backpressure_burst";
        sent0 = sent;
        committed0 = committed;
        saw_full = 1'b0;
        stall_mode = 1'b1;
        repeat (STALL_INSTS)
            send_inst(rand_inst(1'b1));
        wait_drain();
        stall_mode = 1'b0;
        if (!saw_full) begin
            errors++;
            $display("%s: in_ready never dropped while commits were stalled", test_name);
        end
        check_count("commit count", sent - sent0, committed - committed0);
    endtask

    task automatic tag_recycling();
        test_name = "tag_recycling";
        repeat (RECYCLE_INSTS) begin
            send_inst(rand_inst(1'b0));
            if ($urandom_range(3, 0) == 0)
                idle_cycle();
        end
        wait_drain();
    endtask

    task automatic zero_register_reads();
        ooo_core_pkg::inst_t inst;
        test_name = "zero_register_reads";
        repeat (10) begin
            inst = rand_inst(1'b1);
            inst.rd = 5'd0;
            send_inst(inst);
            inst = rand_inst(1'b0);
            inst.rs1 = 5'd0;
            inst.rs2 = 5'd0;
            inst.use_imm = 1'b0;
            send_inst(inst);
        end
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'hd9c7dc87));
        rst = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        for (int i = 0; i < `OOO_ARCH_REGS; i++)
            shadow[i] = 32'd0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        op_sweep();
        dependency_chains();
        backpressure_burst();
        tag_recycling();
        zero_register_reads();
        test_name = "end_of_run";
        check_count("total commits", sent, committed);
        $display("errors: %0d, checks: %0d, sent: %0d, committed: %0d",
                 errors, checks, sent, committed);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog sized from the instruction count
    initial begin
        #(CLK_PERIOD * (TOTAL_INSTS * 40 + 1000));
        $display("timeout in %s: %0d of %0d instructions committed",
                 test_name, committed, sent);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
